/* src/ac_params.svh */
// constants for the accumulator unit
// vectors are numbered lsb-0, so machine bit n sits at vector bit 11-n
// only EAE mode A shift codes are listed
`ifndef AC_PARAMS_SVH
`define AC_PARAMS_SVH

`define AC_WORD_W 12
`define AC_CNT_W 5

// major opcodes in the top three bits
`define AC_OPC_HI 11
`define AC_OPC_LO 9
`define AC_OP_AND 3'd0
`define AC_OP_TAD 3'd1
`define AC_OP_DCA 3'd3
`define AC_OP_OPR 3'd7

// operate micro-op bit positions
// group select is machine bit 3, IAC doubles as the group 3 marker
`define AC_BIT_GRP 8
`define AC_BIT_CLA 7
`define AC_BIT_CLL 6
`define AC_BIT_MQA 6
`define AC_BIT_CMA 5
`define AC_BIT_CML 4
`define AC_BIT_MQL 4
`define AC_BIT_IAC 0

// group 1 rotate field, machine bits 8-10
`define AC_ROT_HI 3
`define AC_ROT_LO 1
`define AC_ROT_BSW 3'b001
`define AC_ROT_RAL 3'b010
`define AC_ROT_RTL 3'b011
`define AC_ROT_RAR 3'b100
`define AC_ROT_RTR 3'b101

// EAE shift codes, machine bits 8-11
`define AC_EAE_HI 3
`define AC_EAE_LO 0
`define AC_EAE_SHL 4'b1011
`define AC_EAE_ASR 4'b1101
`define AC_EAE_LSR 4'b1111
`define AC_SHIFT_LIMIT 5'd24

`endif

/* src/ac_pkg.sv */
// shared types of the accumulator unit
// acc_regs_t packs link above ac above mq, so it lines up with {link, ac, mq}
`default_nettype none

`include "ac_params.svh"

package ac_pkg;

    typedef logic [`AC_WORD_W-1:0] word_t;
    typedef logic [`AC_CNT_W-1:0]  count_t;

    typedef enum logic [3:0] {
        idle,
        f1,
        f2,
        f3,
        e2,
        e3,
        eae0,
        eae1,
        fin
    } phase_t;

    typedef enum logic [2:0] {
        op_and,
        op_tad,
        op_dca,
        op_grp1,
        op_grp3,
        op_none   // anything that leaves link, ac and mq alone
    } op_kind_t;

    typedef enum logic [1:0] {
        sh_none,
        sh_shl,
        sh_asr,
        sh_lsr
    } shift_kind_t;

    typedef struct packed {
        logic  link;
        word_t ac;
        word_t mq;
    } acc_regs_t;

    typedef struct packed {
        op_kind_t    kind;
        logic        cla;
        logic        cll;
        logic        cma;
        logic        cml;
        logic        iac;
        logic [2:0]  rot;   // group 1 only
        logic        mqa;
        logic        mql;
        shift_kind_t shift; // group 3 only
    } decoded_op_t;

endpackage

`default_nettype wire

/* src/ac_decode.sv */
// instruction decode, purely combinational
// group 2, IOT, ISZ, JMS and JMP all come out as op_none
// group 3 shift codes other than SHL, ASR and LSR give sh_none
`timescale 1ns/1ps
`default_nettype none

`include "ac_params.svh"

module ac_decode (
    input  wire ac_pkg::word_t      instruction,
    output ac_pkg::decoded_op_t     op
);

    logic [2:0] opcode;
    logic [3:0] eae_code;
    logic       grp_bit;

    assign opcode   = instruction[`AC_OPC_HI:`AC_OPC_LO];
    assign eae_code = instruction[`AC_EAE_HI:`AC_EAE_LO];
    assign grp_bit  = instruction[`AC_BIT_GRP];

    always_comb
    begin
        op       = '0;
        op.kind  = ac_pkg::op_none;
        op.shift = ac_pkg::sh_none;

        case (opcode)
            `AC_OP_AND: op.kind = ac_pkg::op_and;
            `AC_OP_TAD: op.kind = ac_pkg::op_tad;
            `AC_OP_DCA: op.kind = ac_pkg::op_dca;
            `AC_OP_OPR:
            begin
                if (!grp_bit)
                begin
                    // group 1
                    op.kind = ac_pkg::op_grp1;
                    op.cla  = instruction[`AC_BIT_CLA];
                    op.cll  = instruction[`AC_BIT_CLL];
                    op.cma  = instruction[`AC_BIT_CMA];
                    op.cml  = instruction[`AC_BIT_CML];
                    op.rot  = instruction[`AC_ROT_HI:`AC_ROT_LO];
                    op.iac  = instruction[`AC_BIT_IAC];
                end
                else if (instruction[`AC_BIT_IAC])
                begin
                    // group 3, mode A
                    op.kind = ac_pkg::op_grp3;
                    op.cla  = instruction[`AC_BIT_CLA];
                    op.mqa  = instruction[`AC_BIT_MQA];
                    op.mql  = instruction[`AC_BIT_MQL];
                    case (eae_code)
                        `AC_EAE_SHL: op.shift = ac_pkg::sh_shl;
                        `AC_EAE_ASR: op.shift = ac_pkg::sh_asr;
                        `AC_EAE_LSR: op.shift = ac_pkg::sh_lsr;
                        default:     op.shift = ac_pkg::sh_none;
                    endcase
                end
            end
            default: ; // not handled by this unit
        endcase
    end

endmodule

`default_nettype wire

/* src/ac_phase_seq.sv */
// phase sequencer, replaces the external major-state machine
// start is taken only while busy is low; the edge after acceptance dispatches
// done pulses for one cycle on the edge that leaves f3, e3 or fin
// no stall input, every phase lasts one cycle except eae1
`timescale 1ns/1ps
`default_nettype none

module ac_phase_seq (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      start,
    input  wire ac_pkg::word_t       instruction,
    input  wire ac_pkg::word_t       operand,
    input  wire ac_pkg::decoded_op_t op,
    input  wire                      loop_active,
    output ac_pkg::word_t            held_instr,
    output ac_pkg::word_t            held_operand,
    output ac_pkg::phase_t           phase,
    output logic                     busy,
    output logic                     done
);

    logic accept;
    logic is_mem;
    logic has_shift;

    assign accept    = start && !busy;
    assign is_mem    = (op.kind == ac_pkg::op_and) || (op.kind == ac_pkg::op_tad) ||
                       (op.kind == ac_pkg::op_dca);
    assign has_shift = (op.kind == ac_pkg::op_grp3) && (op.shift != ac_pkg::sh_none);

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            held_instr   <= instruction;
            held_operand <= operand;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase <= ac_pkg::idle;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (phase)
                ac_pkg::idle:
                begin
                    if (busy)
                        phase <= is_mem ? ac_pkg::e2 : ac_pkg::f1; // decode now valid
                    else if (accept)
                        busy <= 1'b1;
                end
                ac_pkg::f1:   phase <= has_shift ? ac_pkg::eae0 : ac_pkg::f2;
                ac_pkg::f2:   phase <= ac_pkg::f3;
                ac_pkg::e2:   phase <= ac_pkg::e3;
                ac_pkg::eae0: phase <= ac_pkg::eae1;
                ac_pkg::eae1:
                begin
                    if (!loop_active)
                        phase <= ac_pkg::fin;
                end
                ac_pkg::f3, ac_pkg::e3, ac_pkg::fin:
                begin
                    phase <= ac_pkg::idle;
                    busy  <= 1'b0;
                    done  <= 1'b1;
                end
                default: phase <= ac_pkg::idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ac_eae_shift.sv */
// EAE mode A shifts: SHL, ASR and LSR by count plus one places
// count is operand bits 7-11; 24 or more saturates in a single load
// one eae1 cycle per step, plus one trailing cycle with loop_active low
`timescale 1ns/1ps
`default_nettype none

`include "ac_params.svh"

module ac_eae_shift (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire ac_pkg::phase_t      phase,
    input  wire ac_pkg::decoded_op_t op,
    input  wire ac_pkg::word_t       operand,
    input  wire ac_pkg::acc_regs_t   regs,
    output ac_pkg::acc_regs_t        shift_regs,
    output logic                     shift_load,
    output logic                     loop_active
);

    localparam int RW = 2 * `AC_WORD_W + 1;

    ac_pkg::count_t step_cnt;
    ac_pkg::count_t new_count;
    logic           saturate;
    logic           sign;

    assign new_count = operand[`AC_CNT_W-1:0];
    assign saturate  = new_count >= `AC_SHIFT_LIMIT;
    assign sign      = regs.ac[`AC_WORD_W-1];

    // value for the current cycle, taken by the datapath on shift_load
    always_comb
    begin
        shift_regs = regs;
        shift_load = 1'b0;
        case (phase)
            ac_pkg::eae0:
            begin
                if (saturate)
                begin
                    shift_load = 1'b1;
                    if (op.shift == ac_pkg::sh_asr)
                        shift_regs = {RW{sign}};  // all sign
                    else
                        shift_regs = '0;
                end
            end
            ac_pkg::eae1:
            begin
                if (loop_active)
                begin
                    shift_load = 1'b1;
                    case (op.shift)
                        ac_pkg::sh_shl: shift_regs = {regs.ac, regs.mq, 1'b0};
                        ac_pkg::sh_asr:
                            shift_regs = {sign, sign, regs.ac, regs.mq[`AC_WORD_W-1:1]};
                        ac_pkg::sh_lsr:
                            shift_regs = {2'b00, regs.ac, regs.mq[`AC_WORD_W-1:1]};
                        default: shift_regs = regs;
                    endcase
                end
            end
            default: ;
        endcase
    end

    // step counter and loop flag
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            step_cnt    <= '0;
            loop_active <= 1'b0;
        end
        else
        begin
            case (phase)
                ac_pkg::eae0:
                begin
                    step_cnt    <= saturate ? '0 : new_count + ac_pkg::count_t'(1);
                    loop_active <= !saturate;
                end
                ac_pkg::eae1:
                begin
                    if (loop_active)
                    begin
                        step_cnt <= step_cnt - ac_pkg::count_t'(1);
                        if (step_cnt == ac_pkg::count_t'(1))
                            loop_active <= 1'b0;  // last step taken
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/ac_datapath.sv */
// link, ac and mq registers with the per-phase micro-operations
// group 1 order is clear/complement in f1, IAC in f2, rotate in f3
// group 3 MQ ops happen in f1, EAE results arrive through shift_load
`timescale 1ns/1ps
`default_nettype none

`include "ac_params.svh"

module ac_datapath (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire ac_pkg::phase_t      phase,
    input  wire ac_pkg::decoded_op_t op,
    input  wire ac_pkg::word_t       operand,
    input  wire ac_pkg::acc_regs_t   shift_regs,
    input  wire                      shift_load,
    output ac_pkg::acc_regs_t        regs
);

    localparam int LW   = `AC_WORD_W + 1; // link plus ac
    localparam int HALF = `AC_WORD_W / 2;

    ac_pkg::acc_regs_t regs_n;
    logic [LW-1:0]     lac;

    function automatic logic [LW-1:0] rot_l(input logic [LW-1:0] v);
        return {v[LW-2:0], v[LW-1]};
    endfunction

    function automatic logic [LW-1:0] rot_r(input logic [LW-1:0] v);
        return {v[0], v[LW-1:1]};
    endfunction

    assign lac = {regs.link, regs.ac};

    always_comb
    begin
        regs_n = regs;
        case (phase)
            ac_pkg::f1:
            begin
                if (op.kind == ac_pkg::op_grp1)
                begin
                    if (op.cla)
                        regs_n.ac = '0;
                    if (op.cma)
                        regs_n.ac = ~regs_n.ac;   // CLA CMA gives 7777
                    if (op.cll)
                        regs_n.link = 1'b0;
                    if (op.cml)
                        regs_n.link = ~regs_n.link;
                end
                else if (op.kind == ac_pkg::op_grp3)
                begin
                    case ({op.cla, op.mqa, op.mql})
                        3'b001:
                        begin
                            regs_n.mq = regs.ac;  // MQL
                            regs_n.ac = '0;
                        end
                        3'b010: regs_n.ac = regs.ac | regs.mq;  // MQA
                        3'b011:
                        begin
                            regs_n.ac = regs.mq;  // SWP
                            regs_n.mq = regs.ac;
                        end
                        3'b100: regs_n.ac = '0;
                        3'b101:
                        begin
                            regs_n.ac = '0;       // CAM
                            regs_n.mq = '0;
                        end
                        3'b110: regs_n.ac = regs.mq;  // ACL
                        3'b111:
                        begin
                            regs_n.ac = regs.mq;
                            regs_n.mq = '0;
                        end
                        default: ;
                    endcase
                end
            end
            ac_pkg::f2:
            begin
                if (op.kind == ac_pkg::op_grp1 && op.iac)
                    {regs_n.link, regs_n.ac} = lac + LW'(1); // 7777 carries into link
            end
            ac_pkg::f3:
            begin
                if (op.kind == ac_pkg::op_grp1)
                begin
                    case (op.rot)
                        `AC_ROT_BSW: regs_n.ac = {regs.ac[HALF-1:0], regs.ac[`AC_WORD_W-1:HALF]};
                        `AC_ROT_RAL: {regs_n.link, regs_n.ac} = rot_l(lac);
                        `AC_ROT_RTL: {regs_n.link, regs_n.ac} = rot_l(rot_l(lac));
                        `AC_ROT_RAR: {regs_n.link, regs_n.ac} = rot_r(lac);
                        `AC_ROT_RTR: {regs_n.link, regs_n.ac} = rot_r(rot_r(lac));
                        default: ;  // remaining codes rotate nothing
                    endcase
                end
            end
            ac_pkg::e2:
            begin
                if (op.kind == ac_pkg::op_and)
                    regs_n.ac = regs.ac & operand;
                else if (op.kind == ac_pkg::op_tad)
                    {regs_n.link, regs_n.ac} = lac + {1'b0, operand};
            end
            ac_pkg::e3:
            begin
                if (op.kind == ac_pkg::op_dca)
                    regs_n.ac = '0;   // word already stored
            end
            ac_pkg::eae0, ac_pkg::eae1:
            begin
                if (shift_load)
                    regs_n = shift_regs;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            regs <= '0;
        else
            regs <= regs_n;
    end

endmodule

`default_nettype wire

/* src/ac_unit.sv */
// accumulator unit of a 12-bit minicomputer
// start is a one-cycle strobe, ignored while busy is high
// regs is valid with the final result while done is high
// memory reference words come in on operand, captured at start
`timescale 1ns/1ps
`default_nettype none

module ac_unit (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 start,
    input  wire ac_pkg::word_t  instruction,
    input  wire ac_pkg::word_t  operand,
    output ac_pkg::acc_regs_t   regs,
    output logic                busy,
    output logic                done
);

    ac_pkg::word_t       held_instr;
    ac_pkg::word_t       held_operand;
    ac_pkg::phase_t      phase;
    ac_pkg::decoded_op_t op;
    ac_pkg::acc_regs_t   shift_regs;
    logic                shift_load;
    logic                loop_active;

    ac_phase_seq u_phase_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .instruction  (instruction),
        .operand      (operand),
        .op           (op),
        .loop_active  (loop_active),
        .held_instr   (held_instr),
        .held_operand (held_operand),
        .phase        (phase),
        .busy         (busy),
        .done         (done)
    );

    ac_decode u_decode (
        .instruction (held_instr),
        .op          (op)
    );

    ac_datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .phase      (phase),
        .op         (op),
        .operand    (held_operand),
        .shift_regs (shift_regs),
        .shift_load (shift_load),
        .regs       (regs)
    );

    ac_eae_shift u_eae_shift (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase       (phase),
        .op          (op),
        .operand     (held_operand),
        .regs        (regs),
        .shift_regs  (shift_regs),
        .shift_load  (shift_load),
        .loop_active (loop_active)
    );

endmodule

`default_nettype wire

/* testbench/tb_ac_model.svh */
// reference model, one call per instruction gives the next {link, ac, mq}
// octal instruction bit n is vector bit n, lsb first
// group 2, IOT, ISZ, JMS and JMP leave the state alone
`ifndef TB_AC_MODEL_SVH
`define TB_AC_MODEL_SVH

function automatic logic [12:0] rotate_left13(input logic [12:0] v, input int k);
    logic [25:0] twice;
    twice = {v, v} << k;
    return twice[25:13];
endfunction

function automatic ac_pkg::acc_regs_t mem_ref_result(input ac_pkg::word_t instr,
                                                     input ac_pkg::word_t word,
                                                     input ac_pkg::acc_regs_t s);
    ac_pkg::acc_regs_t r;
    logic [12:0]       sum;
    r   = s;
    sum = {1'b0, s.ac} + {1'b0, word};
    case (instr[11:9])
        `AC_OP_AND: r.ac = s.ac & word;
        `AC_OP_TAD:
        begin
            r.ac   = sum[11:0];
            r.link = s.link ^ sum[12];  // carry out flips link
        end
        `AC_OP_DCA: r.ac = 12'o0000;
        default: ;
    endcase
    return r;
endfunction

function automatic ac_pkg::acc_regs_t group1_result(input ac_pkg::word_t instr,
                                                    input ac_pkg::acc_regs_t s);
    ac_pkg::acc_regs_t r;
    logic [12:0]       la;
    r      = s;
    r.ac   = instr[7] ? 12'o0000 : r.ac;  // CLA, then CMA
    r.ac   = instr[5] ? ~r.ac : r.ac;
    r.link = instr[6] ? 1'b0 : r.link;    // CLL, then CML
    r.link = instr[4] ? ~r.link : r.link;
    la     = {r.link, r.ac} + {12'd0, instr[0]};
    case (instr[3:1])
        3'b010: la = rotate_left13(la, 1);   // RAL
        3'b011: la = rotate_left13(la, 2);   // RTL
        3'b100: la = rotate_left13(la, 12);  // RAR is left by 12 of 13
        3'b101: la = rotate_left13(la, 11);  // RTR
        3'b001: la[11:0] = {la[5:0], la[11:6]};
        default: ;
    endcase
    {r.link, r.ac} = la;
    return r;
endfunction

function automatic ac_pkg::acc_regs_t group3_result(input ac_pkg::word_t instr,
                                                    input ac_pkg::word_t word,
                                                    input ac_pkg::acc_regs_t s);
    ac_pkg::acc_regs_t r;
    ac_pkg::word_t     ac_cla;
    logic [24:0]       lam;
    logic [23:0]       am;
    logic              sat;
    int                n;
    ac_cla = instr[7] ? 12'o0000 : s.ac;
    r      = s;
    r.ac   = (instr[6] ? s.mq : 12'o0000) | (instr[4] ? 12'o0000 : ac_cla);
    r.mq   = instr[4] ? ac_cla : s.mq;
    sat    = word[4:0] >= 5'd24;
    n      = int'(word[4:0]) + 1;  // count plus one places
    lam    = r;
    am     = {r.ac, r.mq};
    case (instr[3:0])
        4'b1011: lam = sat ? 25'd0 : lam << n;
        4'b1101: lam = sat ? {25{am[23]}} : {am[23], $signed(am) >>> n};
        4'b1111: lam = sat ? 25'd0 : {1'b0, am >> n};
        default: ;
    endcase
    r = lam;
    return r;
endfunction

function automatic ac_pkg::acc_regs_t predict_regs(input ac_pkg::word_t instr,
                                                   input ac_pkg::word_t word,
                                                   input ac_pkg::acc_regs_t s);
    ac_pkg::acc_regs_t r;
    r = s;
    if (instr[11:9] == `AC_OP_AND || instr[11:9] == `AC_OP_TAD || instr[11:9] == `AC_OP_DCA)
        r = mem_ref_result(instr, word, s);
    else if (instr[11:9] == `AC_OP_OPR && !instr[8])
        r = group1_result(instr, s);
    else if (instr[11:9] == `AC_OP_OPR && instr[0])
        r = group3_result(instr, word, s);
    return r;
endfunction

`endif

/* testbench/tb_ac_unit.sv */
// testbench for the accumulator unit
// state carries over between table entries
// expected link, ac and mq come from the model in tb_ac_model.svh
// inputs change on the falling edge and outputs are sampled there too
// shift latency is only bounded by the done timeout
`timescale 1ns/1ps
`default_nettype none

`include "ac_params.svh"

module tb_ac_unit;

    localparam int DONE_TIMEOUT = 64;

    typedef struct packed {
        ac_pkg::word_t     instr;
        ac_pkg::word_t     word;      // memory word or shift count
        logic [3:0]        latency;   // 0 when it depends on the count
        logic              poke;      // second start while busy
        ac_pkg::acc_regs_t exp_regs;
    } vector_t;

    logic              clk;
    logic              rst_n;
    logic              start;
    ac_pkg::word_t     instruction;
    ac_pkg::word_t     operand;
    ac_pkg::acc_regs_t regs;
    logic              busy;
    logic              done;

    vector_t           table_q[$];
    ac_pkg::acc_regs_t model_state;
    int                errors;
    int                checks;
    logic              timed_out;

    `include "tb_ac_model.svh"

    ac_unit u_ac_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .instruction (instruction),
        .operand     (operand),
        .regs        (regs),
        .busy        (busy),
        .done        (done)
    );

    always #4 clk = ~clk;  // 8 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare_value(input string name, input logic [11:0] got,
                                 input logic [11:0] want);
        checks++;
        assert (got === want)
        else
        begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %o got %o", $time, name, want, got);
        end
    endtask

    task automatic check_regs(input ac_pkg::acc_regs_t want);
        compare_value("regs.link", {11'b0, regs.link}, {11'b0, want.link});
        compare_value("regs.ac", regs.ac, want.ac);
        compare_value("regs.mq", regs.mq, want.mq);
    endtask

    task automatic add_vector(input ac_pkg::word_t instr, input ac_pkg::word_t word,
                              input int lat, input logic poke);
        vector_t v;
        model_state = predict_regs(instr, word, model_state);
        v.instr     = instr;
        v.word      = word;
        v.latency   = lat[3:0];
        v.poke      = poke;
        v.exp_regs  = model_state;
        table_q.push_back(v);
    endtask

    task automatic build_table();
        logic [31:0]   seed;
        ac_pkg::word_t shifts [3];
        int            counts [6];
        int            i;
        int            s;
        int            c;
        int            neg;
        seed        = 32'h9b7b;
        shifts      = '{12'o7413, 12'o7415, 12'o7417};  // SHL ASR LSR
        counts      = '{0, 5, 11, 23, 24, 31};
        model_state = '0;
        add_vector(12'o1100, 12'o5432, 3, 1'b0);  // TAD
        add_vector(12'o1101, 12'o3000, 3, 1'b1);  // carries into link
        add_vector(12'o0200, 12'o0770, 3, 1'b0);  // AND
        add_vector(12'o3300, 12'o7777, 3, 1'b0);  // DCA
        add_vector(12'o1100, 12'o2525, 3, 1'b0);
        // every mix of CLA CLL CMA CML
        for (i = 0; i < 16; i++)
            add_vector(12'o7000 | ac_pkg::word_t'(i << 4), 12'o0000, 4, i == 5);
        add_vector(12'o7240, 12'o0000, 4, 1'b0);  // ac 7777
        add_vector(12'o7001, 12'o0000, 4, 1'b0);  // IAC wraps
        add_vector(12'o7241, 12'o0000, 4, 1'b0);
        add_vector(12'o7300, 12'o0000, 4, 1'b0);
        add_vector(12'o1000, 12'o1357, 3, 1'b0);
        add_vector(12'o7004, 12'o0000, 4, 1'b0);  // RAL
        add_vector(12'o7006, 12'o0000, 4, 1'b0);  // RTL
        add_vector(12'o7010, 12'o0000, 4, 1'b1);  // RAR
        add_vector(12'o7012, 12'o0000, 4, 1'b0);  // RTR
        add_vector(12'o7002, 12'o0000, 4, 1'b0);  // BSW
        add_vector(12'o7024, 12'o0000, 4, 1'b0);
        // group 3 MQ ops
        add_vector(12'o7621, 12'o0000, 4, 1'b0);  // CAM
        add_vector(12'o1000, 12'o1234, 3, 1'b0);
        add_vector(12'o7421, 12'o0000, 4, 1'b0);  // MQL
        add_vector(12'o1000, 12'o0707, 3, 1'b0);
        add_vector(12'o7501, 12'o0000, 4, 1'b0);  // MQA
        add_vector(12'o7521, 12'o0000, 4, 1'b1);  // SWP
        add_vector(12'o7601, 12'o0000, 4, 1'b0);
        add_vector(12'o1000, 12'o4321, 3, 1'b0);
        add_vector(12'o7421, 12'o0000, 4, 1'b0);
        add_vector(12'o1000, 12'o0055, 3, 1'b0);
        add_vector(12'o7701, 12'o0000, 4, 1'b0);  // ACL
        add_vector(12'o1000, 12'o0100, 3, 1'b0);
        add_vector(12'o7721, 12'o0000, 4, 1'b0);
        // shifts with the upper operand bits set to show only the count counts
        for (s = 0; s < 3; s++)
            for (c = 0; c < 6; c++)
                for (neg = 0; neg < 2; neg++)
                begin
                    add_vector(12'o7300, 12'o0000, 4, 1'b0);
                    add_vector(12'o1000, (neg != 0) ? 12'o7070 : 12'o1234, 3, 1'b0);
                    add_vector(12'o7421, 12'o0000, 4, 1'b0);
                    add_vector(12'o1000, (neg != 0) ? 12'o6543 : 12'o3456, 3, 1'b0);
                    add_vector(shifts[s], 12'o7740 | ac_pkg::word_t'(counts[c]), 0, c == 3);
                end
        // random TAD and AND at roughly three to one
        for (i = 0; i < 24; i++)
        begin
            seed = lcg_next(seed);
            add_vector({(seed[30:29] == 2'b00) ? 3'o0 : 3'o1, seed[8:0]}, seed[27:16], 3,
                       1'b0);
        end
    endtask

    task automatic apply_vector(input vector_t v, input int index);
        int waited;
        @(negedge clk);
        compare_value("done", {11'b0, done}, 12'o0000);  // one cycle only
        instruction = v.instr;
        operand     = v.word;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        compare_value("busy", {11'b0, busy}, 12'o0001);
        if (v.poke)
        begin
            start       = 1'b1;  // must be ignored
            instruction = 12'o7240;
            operand     = 12'o7777;
        end
        waited = 0;
        while (done !== 1'b1 && waited < DONE_TIMEOUT)
        begin
            @(negedge clk);
            start = 1'b0;
            waited++;
        end
        if (done !== 1'b1)
        begin
            errors++;
            timed_out = 1'b1;
            $display("entry %0d, instruction %o: no done within %0d cycles", index, v.instr,
                     DONE_TIMEOUT);
        end
        else
        begin
            if (v.latency != 4'd0)
                compare_value("done latency", 12'(waited), {8'b0, v.latency});
            compare_value("busy", {11'b0, busy}, 12'o0000);  // falls with done
            check_regs(v.exp_regs);
        end
    endtask

    initial
    begin
        int idx;
        clk         = 1'b0;
        rst_n       = 1'b0;
        start       = 1'b0;
        instruction = '0;
        operand     = '0;
        errors      = 0;
        checks      = 0;
        timed_out   = 1'b0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_value("busy", {11'b0, busy}, 12'o0000);
        compare_value("done", {11'b0, done}, 12'o0000);
        check_regs('0);
        idx = 0;
        while (idx < table_q.size() && !timed_out)
        begin
            apply_vector(table_q[idx], idx);
            idx++;
        end
        $display("summary: %0d errors in %0d checks, %0d of %0d entries run", errors, checks,
                 idx, table_q.size());
        if (errors == 0 && !timed_out)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+src
+incdir+testbench
src/ac_pkg.sv
src/ac_decode.sv
src/ac_phase_seq.sv
src/ac_eae_shift.sv
src/ac_datapath.sv
src/ac_unit.sv
testbench/tb_ac_unit.sv

/* Makefile */
# Verilator build and run of the accumulator unit testbench
VERILATOR = verilator
VFLAGS    = --binary -j 0 --assert
TOP       = tb_ac_unit
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
